/* common/npu_defs.svh */
`ifndef NPU_DEFS_SVH
`define NPU_DEFS_SVH

// Memory depths
`define NPU_BUF_DEPTH   256
`define NPU_INST_DEPTH  64

// Instruction word fields with bits 63:56 unused
`define NPU_F_OPCODE    3:0
`define NPU_F_SHIFT     7:4
`define NPU_F_LEN       15:8
`define NPU_F_DSTART    23:16
`define NPU_F_WSTART    31:24
`define NPU_F_DEST      39:32
`define NPU_F_BIAS      55:40

// APB address map
`define NPU_ADDR_CTRL   12'h000
`define NPU_ADDR_STATUS 12'h004
`define NPU_INST_BASE   3'b010     // paddr[11:9]
`define NPU_DATA_BASE   2'b10      // paddr[11:10]
`define NPU_WGT_BASE    2'b11      // paddr[11:10]
`define NPU_INST_IDX    8:3
`define NPU_INST_HI     2          // Upper half of the 64-bit word
`define NPU_BUF_IDX     9:2

`endif

/* common/npu_pkg.sv */
package npu_pkg;

    // Arithmetic widths
    typedef logic signed [7:0]  elem_t;
    typedef logic signed [15:0] bias_t;
    typedef logic signed [23:0] acc_t;     // 255 full-scale products plus bias still fit
    typedef logic [3:0]         shift_t;

    // Buffer and program addressing
    typedef logic [7:0]  buf_addr_t;
    typedef logic [7:0]  len_t;
    typedef logic [5:0]  pc_t;
    typedef logic [63:0] inst_t;

    // APB side
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [3:0] {
        OP_DOT      = 4'h1,
        OP_DOT_RELU = 4'h2,
        OP_HALT     = 4'hF
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        ISSUE,
        WAIT_EXEC,
        STOP
    } dec_state_e;

endpackage

/* hw/mem/host_mem.sv */
`timescale 1ns/1ps
`include "npu_defs.svh"

module host_mem (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  npu_pkg::apb_addr_t i_paddr,
    input  npu_pkg::apb_data_t i_pwdata,
    output npu_pkg::apb_data_t o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    output logic               o_start,
    input  logic               i_busy,
    input  logic               i_done,
    input  logic               i_error,
    input  logic               i_inst_rd_en,
    input  npu_pkg::pc_t       i_inst_addr,
    output npu_pkg::inst_t     o_inst,
    input  logic               i_buf_rd_en,
    input  npu_pkg::buf_addr_t i_data_raddr,
    input  npu_pkg::buf_addr_t i_wgt_raddr,
    output npu_pkg::elem_t     o_data_elem,
    output npu_pkg::elem_t     o_wgt_elem,
    input  logic               i_wr_en,
    input  npu_pkg::buf_addr_t i_wr_addr,
    input  npu_pkg::elem_t     i_wr_data
);

    npu_pkg::inst_t inst_mem [`NPU_INST_DEPTH];
    npu_pkg::elem_t data_mem [`NPU_BUF_DEPTH];
    npu_pkg::elem_t wgt_mem  [`NPU_BUF_DEPTH];

    logic               access;
    logic               sel_ctrl, sel_stat, sel_inst, sel_data, sel_wgt, sel_mem;
    logic               mem_rd;
    logic               mem_wr;
    logic               rd_wait_r;
    logic               done_r;
    logic               err_r;
    npu_pkg::apb_data_t rd_data_r;
    npu_pkg::pc_t       apb_inst_idx;
    npu_pkg::buf_addr_t apb_buf_idx;

    ////////////////////////////////////////////////////////////
    // APB address decode and handshake
    ////////////////////////////////////////////////////////////

    assign access   = i_psel && i_penable;
    assign sel_ctrl = (i_paddr == `NPU_ADDR_CTRL);
    assign sel_stat = (i_paddr == `NPU_ADDR_STATUS);
    assign sel_inst = (i_paddr[11:9] == `NPU_INST_BASE);
    assign sel_data = (i_paddr[11:10] == `NPU_DATA_BASE);
    assign sel_wgt  = (i_paddr[11:10] == `NPU_WGT_BASE);
    assign sel_mem  = sel_inst || sel_data || sel_wgt;

    assign apb_inst_idx = i_paddr[`NPU_INST_IDX];
    assign apb_buf_idx  = i_paddr[`NPU_BUF_IDX];

    assign mem_rd = access && !i_pwrite && sel_mem;
    assign mem_wr = access && i_pwrite && sel_mem && !i_busy;   // Host locked out while running

    // One wait cycle for memory reads only
    assign o_pready  = access && (!mem_rd || rd_wait_r);
    assign o_pslverr = access && i_pwrite && (sel_mem ? i_busy : !(sel_ctrl || sel_stat));
    assign o_start   = access && i_pwrite && sel_ctrl && i_pwdata[0] && !i_busy;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_wait_r <= 1'b0;
        end else begin
            rd_wait_r <= mem_rd && !rd_wait_r;
        end
    end

    // Sticky completion flags that a new run clears
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done_r <= 1'b0;
            err_r  <= 1'b0;
        end else if (o_start) begin
            done_r <= 1'b0;
            err_r  <= 1'b0;
        end else begin
            if (i_done) begin
                done_r <= 1'b1;
            end
            if (i_error) begin
                err_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (mem_rd && !rd_wait_r) begin
            if (sel_inst) begin
                rd_data_r <= i_paddr[`NPU_INST_HI] ? inst_mem[apb_inst_idx][63:32]
                                                   : inst_mem[apb_inst_idx][31:0];
            end else if (sel_data) begin
                rd_data_r <= npu_pkg::apb_data_t'(data_mem[apb_buf_idx]);  // Sign-extended
            end else begin
                rd_data_r <= npu_pkg::apb_data_t'(wgt_mem[apb_buf_idx]);
            end
        end
    end

    always_comb begin
        if (sel_stat) begin
            o_prdata = {29'd0, err_r, done_r, i_busy};
        end else if (sel_mem) begin
            o_prdata = rd_data_r;
        end else begin
            o_prdata = '0;    // CTRL and holes read as zero
        end
    end

    ////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (mem_wr && sel_inst) begin
            if (i_paddr[`NPU_INST_HI]) begin
                inst_mem[apb_inst_idx][63:32] <= i_pwdata;
            end else begin
                inst_mem[apb_inst_idx][31:0] <= i_pwdata;
            end
        end
        if (i_inst_rd_en) begin
            o_inst <= inst_mem[i_inst_addr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            data_mem[i_wr_addr] <= i_wr_data;     // Result write-back has priority
        end else if (mem_wr && sel_data) begin
            data_mem[apb_buf_idx] <= i_pwdata[7:0];
        end
        if (mem_wr && sel_wgt) begin
            wgt_mem[apb_buf_idx] <= i_pwdata[7:0];
        end
    end

    // Operand pair for the MAC pipe
    always_ff @(posedge i_clk) begin
        if (i_buf_rd_en) begin
            o_data_elem <= data_mem[i_data_raddr];
            o_wgt_elem  <= wgt_mem[i_wgt_raddr];
        end
    end

endmodule

/* hw/inst_decode.sv */
`timescale 1ns/1ps
`include "npu_defs.svh"

module inst_decode (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  npu_pkg::inst_t     i_inst,
    input  logic               i_acc_valid,
    output logic               o_inst_rd_en,
    output npu_pkg::pc_t       o_inst_addr,
    output logic               o_issue,
    output npu_pkg::len_t      o_len,
    output npu_pkg::buf_addr_t o_data_start,
    output npu_pkg::buf_addr_t o_wgt_start,
    output npu_pkg::bias_t     o_bias,
    output npu_pkg::shift_t    o_shift,
    output logic               o_relu,
    output npu_pkg::buf_addr_t o_dest,
    output logic               o_busy,
    output logic               o_done,
    output logic               o_error
);

    npu_pkg::dec_state_e state_r;
    npu_pkg::dec_state_e state_nxt;
    npu_pkg::pc_t        pc_r;
    npu_pkg::opcode_e    opcode;
    logic                op_dot;
    logic                op_halt;

    assign opcode  = npu_pkg::opcode_e'(i_inst[`NPU_F_OPCODE]);
    assign op_dot  = (opcode == npu_pkg::OP_DOT) || (opcode == npu_pkg::OP_DOT_RELU);
    assign op_halt = (opcode == npu_pkg::OP_HALT);

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            npu_pkg::IDLE,
            npu_pkg::STOP: begin
                if (i_start) begin
                    state_nxt = npu_pkg::FETCH;
                end
            end
            npu_pkg::FETCH:  state_nxt = npu_pkg::DECODE;
            npu_pkg::DECODE: state_nxt = op_dot ? npu_pkg::ISSUE : npu_pkg::STOP;
            npu_pkg::ISSUE:  state_nxt = npu_pkg::WAIT_EXEC;
            npu_pkg::WAIT_EXEC: begin
                if (i_acc_valid) begin
                    state_nxt = npu_pkg::FETCH;   // Result write lands during this fetch
                end
            end
            default: state_nxt = npu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= npu_pkg::IDLE;
            pc_r    <= '0;
        end else begin
            state_r <= state_nxt;
            if (i_start) begin
                pc_r <= '0;
            end else if (state_r == npu_pkg::WAIT_EXEC && i_acc_valid) begin
                pc_r <= pc_r + 1'b1;    // Wraps at 64
            end
        end
    end

    // Field split of the fetched word
    always_ff @(posedge i_clk) begin
        if (state_r == npu_pkg::DECODE) begin
            o_len        <= i_inst[`NPU_F_LEN];
            o_data_start <= i_inst[`NPU_F_DSTART];
            o_wgt_start  <= i_inst[`NPU_F_WSTART];
            o_dest       <= i_inst[`NPU_F_DEST];
            o_bias       <= i_inst[`NPU_F_BIAS];
            o_shift      <= i_inst[`NPU_F_SHIFT];
            o_relu       <= (opcode == npu_pkg::OP_DOT_RELU);
        end
    end

    assign o_inst_rd_en = (state_r == npu_pkg::FETCH);
    assign o_inst_addr  = pc_r;
    assign o_issue      = (state_r == npu_pkg::ISSUE);
    assign o_busy       = (state_r != npu_pkg::IDLE) && (state_r != npu_pkg::STOP);
    assign o_done       = (state_r == npu_pkg::DECODE) && op_halt;
    assign o_error      = (state_r == npu_pkg::DECODE) && !op_dot && !op_halt;

endmodule

/* hw/dot_execute.sv */
`timescale 1ns/1ps

module dot_execute (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_issue,
    input  npu_pkg::len_t      i_len,
    input  npu_pkg::buf_addr_t i_data_start,
    input  npu_pkg::buf_addr_t i_wgt_start,
    input  npu_pkg::elem_t     i_data_elem,
    input  npu_pkg::elem_t     i_wgt_elem,
    output logic               o_buf_rd_en,
    output npu_pkg::buf_addr_t o_data_raddr,
    output npu_pkg::buf_addr_t o_wgt_raddr,
    output logic               o_acc_valid,
    output npu_pkg::acc_t      o_acc
);

    logic          run_r;
    npu_pkg::len_t cnt_r;
    logic          pair_vld_r;     // Elements on the read ports this cycle
    logic          pair_last_r;
    npu_pkg::acc_t prod;

    ////////////////////////////////////////////////////////////
    // Read stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_r <= 1'b0;
            cnt_r <= '0;
        end else if (i_issue) begin
            run_r <= (i_len != '0);
            cnt_r <= i_len;
        end else if (run_r) begin
            run_r <= (cnt_r != 8'd1);
            cnt_r <= cnt_r - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_issue) begin
            o_data_raddr <= i_data_start;
            o_wgt_raddr  <= i_wgt_start;
        end else if (run_r) begin
            o_data_raddr <= o_data_raddr + 1'b1;   // Wraps at 256
            o_wgt_raddr  <= o_wgt_raddr + 1'b1;
        end
    end

    assign o_buf_rd_en = run_r;

    ////////////////////////////////////////////////////////////
    // Multiply-accumulate stage
    ////////////////////////////////////////////////////////////

    assign prod = npu_pkg::acc_t'(i_data_elem) * npu_pkg::acc_t'(i_wgt_elem);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pair_vld_r  <= 1'b0;
            pair_last_r <= 1'b0;
            o_acc_valid <= 1'b0;
        end else begin
            pair_vld_r  <= run_r;
            pair_last_r <= run_r && (cnt_r == 8'd1);
            o_acc_valid <= pair_last_r || (i_issue && i_len == '0);  // Empty sum right away
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_issue) begin
            o_acc <= '0;
        end else if (pair_vld_r) begin
            o_acc <= o_acc + prod;
        end
    end

endmodule

/* hw/result_writer.sv */
`timescale 1ns/1ps

module result_writer (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_issue,
    input  npu_pkg::bias_t     i_bias,
    input  npu_pkg::shift_t    i_shift,
    input  logic               i_relu,
    input  npu_pkg::buf_addr_t i_dest,
    input  logic               i_acc_valid,
    input  npu_pkg::acc_t      i_acc,
    output logic               o_wr_en,
    output npu_pkg::buf_addr_t o_wr_addr,
    output npu_pkg::elem_t     o_wr_data
);

    npu_pkg::bias_t     bias_r;
    npu_pkg::shift_t    shift_r;
    logic               relu_r;
    npu_pkg::buf_addr_t dest_r;
    npu_pkg::acc_t      biased;
    npu_pkg::acc_t      shifted;
    npu_pkg::acc_t      activated;
    npu_pkg::elem_t     clamped;

    // Controls of the instruction in flight
    always_ff @(posedge i_clk) begin
        if (i_issue) begin
            bias_r  <= i_bias;
            shift_r <= i_shift;
            relu_r  <= i_relu;
            dest_r  <= i_dest;
        end
    end

    assign biased    = i_acc + npu_pkg::acc_t'(bias_r);
    assign shifted   = biased >>> shift_r;
    assign activated = (relu_r && shifted < 0) ? '0 : shifted;

    // Saturate to the signed byte range
    always_comb begin
        if (activated > npu_pkg::acc_t'(127)) begin
            clamped = 8'sd127;
        end else if (activated < npu_pkg::acc_t'(-128)) begin
            clamped = -8'sd128;
        end else begin
            clamped = activated[7:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_acc_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_acc_valid) begin
            o_wr_addr <= dest_r;
            o_wr_data <= clamped;
        end
    end

endmodule

/* hw/npu_core.sv */
`timescale 1ns/1ps

module npu_core (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  npu_pkg::apb_addr_t i_paddr,
    input  npu_pkg::apb_data_t i_pwdata,
    output npu_pkg::apb_data_t o_prdata,
    output logic               o_pready,
    output logic               o_pslverr
);

    // Run control
    logic start, busy, done, error;

    // Fetch path
    logic           inst_rd_en;
    npu_pkg::pc_t   inst_addr;
    npu_pkg::inst_t inst;

    // Issued instruction fields
    logic               issue;
    logic               relu;
    npu_pkg::len_t      len;
    npu_pkg::buf_addr_t data_start, wgt_start, dest;
    npu_pkg::bias_t     bias;
    npu_pkg::shift_t    shift;

    // Operand reads and result
    logic               buf_rd_en;
    npu_pkg::buf_addr_t data_raddr, wgt_raddr;
    npu_pkg::elem_t     data_elem, wgt_elem;
    logic               acc_valid;
    npu_pkg::acc_t      acc;
    logic               wr_en;
    npu_pkg::buf_addr_t wr_addr;
    npu_pkg::elem_t     wr_data;

    host_mem u_host_mem (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_start      (start),
        .i_busy       (busy),
        .i_done       (done),
        .i_error      (error),
        .i_inst_rd_en (inst_rd_en),
        .i_inst_addr  (inst_addr),
        .o_inst       (inst),
        .i_buf_rd_en  (buf_rd_en),
        .i_data_raddr (data_raddr),
        .i_wgt_raddr  (wgt_raddr),
        .o_data_elem  (data_elem),
        .o_wgt_elem   (wgt_elem),
        .i_wr_en      (wr_en),
        .i_wr_addr    (wr_addr),
        .i_wr_data    (wr_data)
    );

    inst_decode u_inst_decode (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (start),
        .i_inst       (inst),
        .i_acc_valid  (acc_valid),
        .o_inst_rd_en (inst_rd_en),
        .o_inst_addr  (inst_addr),
        .o_issue      (issue),
        .o_len        (len),
        .o_data_start (data_start),
        .o_wgt_start  (wgt_start),
        .o_bias       (bias),
        .o_shift      (shift),
        .o_relu       (relu),
        .o_dest       (dest),
        .o_busy       (busy),
        .o_done       (done),
        .o_error      (error)
    );

    dot_execute u_dot_execute (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_issue      (issue),
        .i_len        (len),
        .i_data_start (data_start),
        .i_wgt_start  (wgt_start),
        .i_data_elem  (data_elem),
        .i_wgt_elem   (wgt_elem),
        .o_buf_rd_en  (buf_rd_en),
        .o_data_raddr (data_raddr),
        .o_wgt_raddr  (wgt_raddr),
        .o_acc_valid  (acc_valid),
        .o_acc        (acc)
    );

    result_writer u_result_writer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_issue     (issue),
        .i_bias      (bias),
        .i_shift     (shift),
        .i_relu      (relu),
        .i_dest      (dest),
        .i_acc_valid (acc_valid),
        .i_acc       (acc),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data)
    );

endmodule

/* tests/npu_core_props.sv */
`timescale 1ns/1ps

module npu_core_props (
    input logic               i_clk,
    input logic               i_rst_n,
    input logic               i_psel,
    input logic               i_penable,
    input logic               i_pwrite,
    input npu_pkg::apb_addr_t i_paddr,
    input logic               i_pready,
    input logic               i_issue,
    input logic               i_acc_valid,
    input logic               i_wr_en,
    input npu_pkg::buf_addr_t i_wr_addr,
    input logic               i_buf_rd_en,
    input npu_pkg::buf_addr_t i_data_raddr
);

    logic mem_addr;
    logic acc_seen_r;    // Sum delivered since the last issue

    assign mem_addr = (i_paddr[11:9] == 3'b010) || i_paddr[11];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_seen_r <= 1'b0;
        end else if (i_issue) begin
            acc_seen_r <= 1'b0;
        end else if (i_acc_valid) begin
            acc_seen_r <= 1'b1;
        end
    end

    a_pready_in_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pready |-> (i_psel && i_penable))
        else $error("PREADY high outside an access phase");

    a_mem_read_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_psel && !i_penable && !i_pwrite && mem_addr) |=> !i_pready ##1 i_pready)
        else $error("Memory read did not wait exactly one cycle");

    a_acc_once: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_acc_valid |-> !acc_seen_r)
        else $error("Second sum without an issue in between");

    a_no_wr_rd_clash: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_wr_en && i_buf_rd_en && (i_wr_addr == i_data_raddr)))
        else $error("Result write and operand read hit the same data address");

endmodule

bind npu_core npu_core_props u_props (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pready     (o_pready),
    .i_issue      (issue),
    .i_acc_valid  (acc_valid),
    .i_wr_en      (wr_en),
    .i_wr_addr    (wr_addr),
    .i_buf_rd_en  (buf_rd_en),
    .i_data_raddr (data_raddr)
);

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        forever #4 o_clk = ~o_clk;    // 8 ns period
    end

    initial begin
        repeat (4) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

/* tests/tb_npu_core.sv */
`timescale 1ns/1ps
`include "npu_defs.svh"

module tb_npu_core;

    localparam int NRAND       = 4;
    localparam int RAND_BUDGET = 6000;    // Cycles for the random program

    logic               clk, rst_n;
    logic               psel, penable, pwrite;
    npu_pkg::apb_addr_t paddr;
    npu_pkg::apb_data_t pwdata, prdata;
    logic               pready, pslverr;

    string       kind_q[$];
    string       name_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    bit          loaded = 0;
    int          pattern_lines = 0;
    string       cur_test = "";
    int          test_errs = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    logic [31:0] rng_state = 32'd93;

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

    npu_core DUT (
        .i_clk(clk), .i_rst_n(rst_n), .i_psel(psel), .i_penable(penable),
        .i_pwrite(pwrite), .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
    );

    ////////////////////////////////////////////////////////////
    // APB access
    ////////////////////////////////////////////////////////////

    task automatic apb_xfer(input logic wr, input npu_pkg::apb_addr_t addr,
                            input npu_pkg::apb_data_t wdata,
                            output npu_pkg::apb_data_t rdata, output logic err);
        int n;
        n = 0;
        psel   = 1'b1;    // Setup phase
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (!pready && n < 16);
        assert (pready) else begin
            $display("%s: APB transfer to %h never completed", cur_test, addr);
            test_errs++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_word(input npu_pkg::apb_addr_t addr, input npu_pkg::apb_data_t data,
                              input logic exp_err);
        npu_pkg::apb_data_t rd;
        logic err;
        apb_xfer(1'b1, addr, data, rd, err);
        assert (err == exp_err) else begin
            $display("[ERROR] %s: write %h pslverr expected %b actual %b",
                     cur_test, addr, exp_err, err);
            test_errs++;
        end
    endtask

    task automatic read_check(input npu_pkg::apb_addr_t addr, input npu_pkg::apb_data_t exp);
        npu_pkg::apb_data_t rd;
        logic err;
        apb_xfer(1'b0, addr, '0, rd, err);
        assert (rd === exp) else begin
            $display("[ERROR] %s: read %h expected %h actual %h", cur_test, addr, exp, rd);
            test_errs++;
        end
    endtask

    task automatic poll_idle();
        npu_pkg::apb_data_t rd;
        logic err;
        int n;
        n = 0;
        do begin
            apb_xfer(1'b0, `NPU_ADDR_STATUS, '0, rd, err);
            n++;
        end while (rd[0] && n < 2000);
        assert (!rd[0]) else begin
            $display("%s: core still busy after %0d status polls", cur_test, n);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("Test %s: passed", cur_test);
            pass_cnt++;
        end else begin
            $display("Test %s: FAILED with %0d errors", cur_test, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and random source
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Bias, arithmetic shift, optional ReLU, clamp to a signed byte
    function automatic int quantize(input int sum, input int bias, input int shift,
                                    input bit relu);
        int v;
        v = (sum + bias) >>> shift;
        if (relu && v < 0) v = 0;
        if (v > 127) v = 127;
        if (v < -128) v = -128;
        return v;
    endfunction

    task automatic random_test();
        int          exp_q[NRAND];
        int          len, sum, bias, shift, d, w, base;
        bit          relu;
        npu_pkg::inst_t inst;
        cur_test = "random_dot";
        for (int i = 0; i < NRAND; i++) begin
            rng_state = xorshift(rng_state);
            len   = 1 + int'(rng_state[2:0]);
            shift = int'(rng_state[7:4]);
            relu  = rng_state[8];
            bias  = int'($signed(rng_state[31:16])) >>> 3;
            base  = 'h60 + 16 * i;
            sum   = 0;
            for (int j = 0; j < len; j++) begin
                rng_state = xorshift(rng_state);
                d = int'($signed(rng_state[7:0]));
                w = int'($signed(rng_state[15:8]));
                sum += d * w;
                write_word(npu_pkg::apb_addr_t'('h800 + 4 * (base + j)),
                           {24'd0, rng_state[7:0]}, 1'b0);
                write_word(npu_pkg::apb_addr_t'('hC00 + 4 * (base + j)),
                           {24'd0, rng_state[15:8]}, 1'b0);
            end
            exp_q[i] = quantize(sum, bias, shift, relu);
            inst = '0;
            inst[`NPU_F_OPCODE] = relu ? npu_pkg::OP_DOT_RELU : npu_pkg::OP_DOT;
            inst[`NPU_F_SHIFT]  = 4'(shift);
            inst[`NPU_F_LEN]    = 8'(len);
            inst[`NPU_F_DSTART] = 8'(base);
            inst[`NPU_F_WSTART] = 8'(base);
            inst[`NPU_F_DEST]   = 8'('hE0 + i);
            inst[`NPU_F_BIAS]   = bias[15:0];
            write_word(npu_pkg::apb_addr_t'('h400 + 8 * i), inst[31:0], 1'b0);
            write_word(npu_pkg::apb_addr_t'('h404 + 8 * i), inst[63:32], 1'b0);
        end
        write_word(npu_pkg::apb_addr_t'('h400 + 8 * NRAND), {28'd0, npu_pkg::OP_HALT}, 1'b0);
        write_word(npu_pkg::apb_addr_t'('h404 + 8 * NRAND), '0, 1'b0);
        write_word(`NPU_ADDR_CTRL, 32'd1, 1'b0);
        poll_idle();
        read_check(`NPU_ADDR_STATUS, 32'd2);
        for (int i = 0; i < NRAND; i++) begin
            read_check(npu_pkg::apb_addr_t'('h800 + 4 * ('hE0 + i)), exp_q[i]);
        end
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Pattern reader and main flow
    ////////////////////////////////////////////////////////////

    initial begin
        int          fd, n;
        string       line, op, name;
        logic [31:0] a, v0, v1, v2, v3;
        logic [31:0] vals[4];
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        fd = $fopen("tests/npu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            $display(">>> FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) continue;
                n = $sscanf(line, "%s %h %h %h %h %h", op, a, v0, v1, v2, v3);
                if (n < 1 || op.getc(0) == "#") continue;
                pattern_lines++;
                if (op == "T") begin
                    void'($sscanf(line, "%s %s", op, name));
                    kind_q.push_back("T");
                    name_q.push_back(name);
                    addr_q.push_back(0);
                    data_q.push_back(0);
                end else begin
                    vals = '{v0, v1, v2, v3};
                    for (int k = 0; k < ((n > 2) ? n - 2 : 1); k++) begin
                        kind_q.push_back(op);
                        name_q.push_back("");
                        addr_q.push_back(a + 4 * k);
                        data_q.push_back(vals[k]);
                    end
                end
            end
            $fclose(fd);
            loaded = 1;
            @(posedge rst_n);
            @(posedge clk);
            #1;
            foreach (kind_q[i]) begin
                case (kind_q[i])
                    "T": begin
                        if (cur_test != "") finish_test();
                        cur_test = name_q[i];
                    end
                    "W": write_word(addr_q[i][11:0], data_q[i], 1'b0);
                    "S": write_word(addr_q[i][11:0], data_q[i], 1'b1);
                    "R": read_check(addr_q[i][11:0], data_q[i]);
                    "P": poll_idle();
                    default: begin
                        $display("Unknown pattern entry %s", kind_q[i]);
                        test_errs++;
                    end
                endcase
            end
            finish_test();
            random_test();
            $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

    // Watchdog sized from the pattern line count
    initial begin
        wait (loaded);
        repeat (pattern_lines * 400 + RAND_BUDGET) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/npu_pkg.sv
hw/mem/host_mem.sv
hw/inst_decode.sv
hw/dot_execute.sv
hw/result_writer.sv
hw/npu_core.sv
tests/npu_core_props.sv
tests/tb_clk_gen.sv
tests/tb_npu_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_npu_core
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= >>> FAIL
PASS_MSG  ?= >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '^$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q '^$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/npu_patterns.txt */
# T name | W addr word.. (consecutive words) | S addr word (expects PSLVERR)
# R addr expected | P (poll STATUS until idle); all values hex
T reset_readback
R 004 00000000
W 800 05
R 800 00000005
W C00 FE
R C00 FFFFFFFE
W 400 12345678 9ABCDEF0
R 400 12345678
R 404 9ABCDEF0
S 100 0
T single_dot
W 800 01 02 03 04
W C00 05 06 07 08
W 400 00000421 00000A10 0000000F 00000000
W 000 1
P
R 004 00000002
R 840 00000014
T relu_saturate
W C20 F6 F6
W 850 7F 7F
W C50 7F 7F 80 80
W 400 08000202 00000011 14140211 00000012
W 410 16140211 00000013 0000000F 00000000
W 000 1
P
R 004 00000002
R 844 00000000
R 848 0000007F
R 84C FFFFFF80
T chained
W 400 00000201 00000020 00200101 00000321
W 410 00000021 00FF3822 0000000F 00000000
W 000 1
P
R 004 00000002
R 880 00000011
R 884 00000058
R 888 FFFFFFCE
T errors
W 900 33
W 400 0000C801 00000030 00000005 00000000
W 000 1
S 900 44
P
R 004 00000004
R 900 00000033
